//--- bench/ssp_card_props.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_card_props #(
    parameter bit [7:0] ID            = 8'd7,
    parameter bit       FORCE_OVERLAY = 1'b0
) (
    input logic                clk_i,
    input logic                reset_i,
    input logic [7:0]          slot_id_i,
    input ssp_pkg::bus_cycle_t cycle_i,
    input ssp_pkg::card_sel_t  sel_i
);

    logic [5:0] strobes;

    // number of assertion failures so far, the testbench folds it into its verdict
    int fail_count = 0;

    // the one-cycle selects without the two soft switch levels
    assign strobes = {sel_i.vdp_wr, sel_i.vdp_rd, sel_i.vdp_reset,
                      sel_i.psg_addr_wr, sel_i.psg_data_wr, sel_i.psg_data_rd};

    // one access selects one function at most
    one_strobe: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(strobes))
        else begin
            $error("more than one select strobe high in one cycle");
            fail_count++;
        end

    // an access for another slot must leave every select low on the next cycle
    foreign_slot: assert property (@(posedge clk_i) disable iff (reset_i)
        (cycle_i.strobe && (slot_id_i != ID)) |=> (strobes == '0))
        else begin
            $error("select strobe fired for an access to another slot");
            fail_count++;
        end

    // right after reset the switches still carry their reset levels
    switch_reset: assert property (@(posedge clk_i)
        $fell(reset_i) |-> (sel_i.apple_sw && (sel_i.overlay_sw == FORCE_OVERLAY)))
        else begin
            $error("soft switches left reset with wrong levels");
            fail_count++;
        end

endmodule

bind ssp_decode ssp_card_props #(
    .ID            (ID),
    .FORCE_OVERLAY (FORCE_OVERLAY)
) u_props (
    .clk_i     (a2bus_if.clk_logic),
    .reset_i   (reset_i),
    .slot_id_i (slot_id_i),
    .cycle_i   (cyc),
    .sel_i     (sel_o)
);

`default_nettype wire

//--- bench/ssp_card_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_card_tb;

    localparam int num_rows = 25;
    // every row takes three cycles and the limit leaves plenty of slack on top
    localparam int timeout_cycles = (num_rows * 4 + 16) * 2;

    localparam logic [1:0] op_idle = 2'd0;
    localparam logic [1:0] op_wr   = 2'd1;
    localparam logic [1:0] op_rd   = 2'd2;

    // which outputs a row compares
    localparam logic [4:0] care_data = 5'b10000;
    localparam logic [4:0] care_rd   = 5'b01000;
    localparam logic [4:0] care_irq  = 5'b00100;
    localparam logic [4:0] care_pix  = 5'b00010;
    localparam logic [4:0] care_aud  = 5'b00001;

    localparam ssp_pkg::rgb8_t ap = 24'h123456;

    typedef struct packed {
        logic [1:0]          op;
        logic [3:0]          addr;
        logic [7:0]          data;
        logic [7:0]          slot;
        ssp_pkg::vdp_pixel_t vdp;
        logic                frame;
        logic [4:0]          care;
        logic [7:0]          exp_data;
        logic                exp_rd_en;
        logic                exp_irq_n;
        ssp_pkg::rgb8_t      exp_pix;
        logic [15:0]         exp_audio;
    } row_t;

    a2bus_if bus ();

    logic                reset;
    logic [7:0]          slot_id;
    logic                frame;
    ssp_pkg::rgb8_t      apple_pix;
    ssp_pkg::vdp_pixel_t vdp_pix;
    logic [7:0]          data;
    logic                rd_en;
    logic                irq_n;
    ssp_pkg::rgb8_t      pix;
    logic [15:0]         audio;

    row_t  rows [num_rows];
    string names [num_rows];
    int    n_rows = 0;
    int    errors = 0;
    int    cycles = 0;

    // a visible vdp colour, its widened form, and two black vdp pixels
    ssp_pkg::vdp_pixel_t vc;
    ssp_pkg::vdp_pixel_t vb;
    ssp_pkg::vdp_pixel_t vt;
    ssp_pkg::rgb8_t      vw;

    ssp_card #(
        .ID            (8'd7),
        .ENABLE        (1'b1),
        .FORCE_OVERLAY (1'b0)
    ) DUT (
        .a2bus_if    (bus),
        .reset_i     (reset),
        .slot_id_i   (slot_id),
        .frame_i     (frame),
        .apple_pix_i (apple_pix),
        .vdp_pix_i   (vdp_pix),
        .data_o      (data),
        .rd_en_o     (rd_en),
        .irq_n_o     (irq_n),
        .pix_o       (pix),
        .audio_o     (audio)
    );

    initial begin
        bus.clk_logic = 1'b0;
        forever begin
            #2 bus.clk_logic = ~bus.clk_logic;
        end
    end

    always @(posedge bus.clk_logic) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // renderer pixel with the valid flag always set
    function automatic ssp_pkg::vdp_pixel_t vdp_px(input logic [3:0] r, g, b, input logic t);
        ssp_pkg::vdp_pixel_t p;
        p.r           = r;
        p.g           = g;
        p.b           = b;
        p.transparent = t;
        p.valid       = 1'b1;
        return p;
    endfunction

    task automatic add_row(input string name, input logic [1:0] op, input logic [3:0] addr,
                           input logic [7:0] wdata, input logic [7:0] slot,
                           input ssp_pkg::vdp_pixel_t vdp, input logic frm,
                           input logic [4:0] care, input logic [7:0] e_data,
                           input logic e_rd, input logic e_irq,
                           input ssp_pkg::rgb8_t e_pix, input logic [15:0] e_aud);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.data      = wdata;
        r.slot      = slot;
        r.vdp       = vdp;
        r.frame     = frm;
        r.care      = care;
        r.exp_data  = e_data;
        r.exp_rd_en = e_rd;
        r.exp_irq_n = e_irq;
        r.exp_pix   = e_pix;
        r.exp_audio = e_aud;
        rows[n_rows]  = r;
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic check_value(input string sig, input logic [23:0] exp_v,
                               input logic [23:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, sig, exp_v, act_v);
            errors++;
        end
    endtask

    // starts on a falling edge and ends on the falling edge three cycles later
    task automatic run_row(input int idx, output logic ok);
        row_t       r;
        int         errors_before;
        logic [7:0] seen_data;
        logic       seen_rd;
        r             = rows[idx];
        errors_before = errors;
        bus.cycle.strobe = (r.op != op_idle);
        bus.cycle.rw_n   = (r.op == op_rd);
        bus.cycle.addr   = r.addr;
        bus.cycle.data   = r.data;
        slot_id = r.slot;
        vdp_pix = r.vdp;
        frame   = r.frame;
        @(negedge bus.clk_logic);
        bus.cycle.strobe = 1'b0;
        frame            = 1'b0;
        // read data is valid for a single cycle two cycles after the strobe
        @(negedge bus.clk_logic);
        seen_data = data;
        seen_rd   = rd_en;
        @(negedge bus.clk_logic);
        if (r.care[4]) check_value("data_o", r.exp_data, seen_data);
        if (r.care[3]) check_value("rd_en_o", r.exp_rd_en, seen_rd);
        if (r.care[2]) check_value("irq_n_o", r.exp_irq_n, irq_n);
        if (r.care[1]) check_value("pix_o", r.exp_pix, pix);
        if (r.care[0]) check_value("audio_o", r.exp_audio, audio);
        ok = (errors == errors_before);
    endtask

    task automatic build_table();
        add_row("reset state", op_idle, 4'h0, 8'h00, 8'd7, vc, 0,
                care_rd | care_irq | care_pix | care_aud, 8'h00, 0, 1, ap, 16'h0000);
        add_row("overlay on in slot 5", op_wr, 4'h6, 8'h00, 8'd5, vc, 0,
                care_rd | care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("overlay on in slot 7", op_wr, 4'h6, 8'h00, 8'd7, vc, 0,
                care_rd | care_pix, 8'h00, 0, 1, vw, 16'h0000);
        add_row("overlay off", op_wr, 4'h5, 8'h00, 8'd7, vc, 0,
                care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("apple video off", op_wr, 4'h3, 8'h00, 8'd7, vc, 0,
                care_pix, 8'h00, 0, 1, 24'h000000, 16'h0000);
        add_row("apple video on", op_wr, 4'h4, 8'h00, 8'd7, vc, 0,
                care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("black vdp pixel keyed", op_wr, 4'h6, 8'h00, 8'd7, vb, 0,
                care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("register 0 first byte", op_wr, 4'h1, 8'h01, 8'd7, vb, 0,
                care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("external video on", op_wr, 4'h1, 8'h80, 8'd7, vb, 0,
                care_pix, 8'h00, 0, 1, 24'h000000, 16'h0000);
        add_row("transparent vdp pixel", op_idle, 4'h0, 8'h00, 8'd7, vt, 0,
                care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("register 1 first byte", op_wr, 4'h1, 8'h20, 8'd7, vt, 0,
                care_irq | care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("interrupt enable", op_wr, 4'h1, 8'h81, 8'd7, vt, 0,
                care_irq, 8'h00, 0, 1, ap, 16'h0000);
        add_row("frame pulse", op_idle, 4'h0, 8'h00, 8'd7, vt, 1,
                care_irq, 8'h00, 0, 0, ap, 16'h0000);
        add_row("status read", op_rd, 4'h1, 8'h00, 8'd7, vt, 0,
                care_data | care_rd | care_irq, 8'h80, 1, 1, ap, 16'h0000);
        add_row("second status read", op_rd, 4'h1, 8'h00, 8'd7, vt, 0,
                care_data | care_rd | care_irq, 8'h00, 1, 1, ap, 16'h0000);
        add_row("vdp reset", op_wr, 4'h7, 8'h00, 8'd7, vb, 0,
                care_irq | care_pix, 8'h00, 0, 1, ap, 16'h0000);
        add_row("frame after vdp reset", op_idle, 4'h0, 8'h00, 8'd7, vb, 1,
                care_irq, 8'h00, 0, 1, ap, 16'h0000);
        add_row("psg address 8", op_wr, 4'hD, 8'h08, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h0000);
        add_row("psg channel A level", op_wr, 4'hC, 8'h0F, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h0F00);
        add_row("psg address 9", op_wr, 4'hD, 8'h09, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h0F00);
        add_row("psg channel B level", op_wr, 4'hC, 8'h03, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h1200);
        add_row("psg readback", op_rd, 4'hE, 8'h00, 8'd7, vb, 0,
                care_data | care_rd | care_aud, 8'h03, 1, 1, ap, 16'h1200);
        add_row("psg address 2", op_wr, 4'hD, 8'h02, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h1200);
        add_row("psg write to register 2", op_wr, 4'hC, 8'h05, 8'd7, vb, 0,
                care_aud, 8'h00, 0, 1, ap, 16'h1200);
        add_row("psg read of register 2", op_rd, 4'hE, 8'h00, 8'd7, vb, 0,
                care_data | care_rd | care_aud, 8'h00, 1, 1, ap, 16'h1200);
    endtask

    initial begin
        logic ok;
        int   passed;
        int   assert_fails;
        passed    = 0;
        reset     = 1'b1;
        bus.cycle = '0;
        slot_id   = 8'd7;
        frame     = 1'b0;
        apple_pix = ap;
        vdp_pix   = '0;
        vc = vdp_px(4'hA, 4'h5, 4'hC, 1'b0);
        // A, 5 and C each sit in the top nibble of their 8 bit channel
        vw = 24'hA050C0;
        vb = vdp_px(4'h0, 4'h0, 4'h0, 1'b0);
        vt = vdp_px(4'h0, 4'h0, 4'h0, 1'b1);
        build_table();
        repeat (16) @(negedge bus.clk_logic);
        reset = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            run_row(i, ok);
            $display("test %0d %s: %s", i, names[i], ok ? "ok" : "wrong");
            if (ok) begin
                passed++;
            end
        end
        assert_fails = DUT.u_decode.u_props.fail_count;
        $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 n_rows, passed, n_rows - passed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/ssp_pkg.sv
hdl/a2bus_if.sv
hdl/ssp_decode.sv
hdl/ssp_vdp_regs.sv
hdl/ssp_psg_regs.sv
hdl/ssp_overlay.sv
hdl/ssp_card.sv
bench/ssp_card_props.sv
bench/ssp_card_tb.sv

//--- hdl/a2bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface a2bus_if;

    // logic clock of the card, everything runs in this single domain
    logic clk_logic;

    // the decoded bus access, already reduced to one strobed cycle
    ssp_pkg::bus_cycle_t cycle;

    // the card only samples the bus
    modport slave (
        input clk_logic,
        input cycle
    );

    // the bus side owns both the clock and the access
    modport master (
        output clk_logic,
        output cycle
    );

endinterface

`default_nettype wire

//--- hdl/ssp_card.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_card #(
    parameter bit [7:0] ID            = 8'd7,
    parameter bit       ENABLE        = 1'b1,
    parameter bit       FORCE_OVERLAY = 1'b0
) (
    a2bus_if.slave              a2bus_if,
    input  logic                reset_i,
    input  logic [7:0]          slot_id_i,
    input  logic                frame_i,
    input  ssp_pkg::rgb8_t      apple_pix_i,
    input  ssp_pkg::vdp_pixel_t vdp_pix_i,
    output logic [7:0]          data_o,
    output logic                rd_en_o,
    output logic                irq_n_o,
    output ssp_pkg::rgb8_t      pix_o,
    output logic [15:0]         audio_o
);

    ssp_pkg::card_sel_t sel;
    logic [7:0] wr_data;
    logic [7:0] vdp_rd_data;
    logic       vdp_rd_en;
    logic       vdp_irq_n;
    logic       ext_video;
    logic [7:0] psg_rd_data;
    logic       psg_rd_en;

    ssp_decode #(
        .ID            (ID),
        .ENABLE        (ENABLE),
        .FORCE_OVERLAY (FORCE_OVERLAY)
    ) u_decode (
        .a2bus_if  (a2bus_if),
        .reset_i   (reset_i),
        .slot_id_i (slot_id_i),
        .sel_o     (sel),
        .wr_data_o (wr_data)
    );

    ssp_vdp_regs u_vdp (
        .clk_i       (a2bus_if.clk_logic),
        .reset_i     (reset_i),
        .sel_i       (sel),
        .wr_data_i   (wr_data),
        .frame_i     (frame_i),
        .rd_data_o   (vdp_rd_data),
        .rd_en_o     (vdp_rd_en),
        .irq_n_o     (vdp_irq_n),
        .ext_video_o (ext_video)
    );

    ssp_psg_regs u_psg (
        .clk_i     (a2bus_if.clk_logic),
        .reset_i   (reset_i),
        .sel_i     (sel),
        .wr_data_i (wr_data),
        .rd_data_o (psg_rd_data),
        .rd_en_o   (psg_rd_en),
        .audio_o   (audio_o)
    );

    ssp_overlay #(
        .ENABLE (ENABLE)
    ) u_overlay (
        .clk_i        (a2bus_if.clk_logic),
        .reset_i      (reset_i),
        .apple_sw_i   (sel.apple_sw),
        .overlay_sw_i (sel.overlay_sw),
        .ext_video_i  (ext_video),
        .apple_pix_i  (apple_pix_i),
        .vdp_pix_i    (vdp_pix_i),
        .pix_o        (pix_o)
    );

    // both read paths have the same latency, so a valid psg read picks the bus
    assign data_o  = psg_rd_en ? psg_rd_data : vdp_rd_data;
    assign rd_en_o = psg_rd_en || vdp_rd_en;

    // a card that is not built in never pulls the shared interrupt line
    assign irq_n_o = vdp_irq_n || !ENABLE;

endmodule

`default_nettype wire

//--- hdl/ssp_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_decode #(
    parameter bit [7:0] ID            = 8'd7,
    parameter bit       ENABLE        = 1'b1,
    parameter bit       FORCE_OVERLAY = 1'b0
) (
    a2bus_if.slave             a2bus_if,
    input  logic               reset_i,
    input  logic [7:0]         slot_id_i,
    output ssp_pkg::card_sel_t sel_o,
    output logic [7:0]         wr_data_o
);

    ssp_pkg::bus_cycle_t cyc;
    logic hit;
    logic wr;
    logic rd;
    logic vdp_addr;
    logic psg_addr;

    assign cyc = a2bus_if.cycle;

    // the card answers only in its own slot and only when built in
    assign hit = ENABLE && cyc.strobe && (slot_id_i == ID);
    assign wr  = hit && !cyc.rw_n;
    assign rd  = hit && cyc.rw_n;

    // vdp takes offsets 0 and 1, the psg takes the top four offsets
    assign vdp_addr = (cyc.addr == ssp_pkg::off_vdp_data) ||
                      (cyc.addr == ssp_pkg::off_vdp_reg);
    assign psg_addr = (cyc.addr[3:2] == ssp_pkg::off_psg_base[3:2]);

    always_ff @(posedge a2bus_if.clk_logic) begin
        if (reset_i) begin
            sel_o            <= '0;
            sel_o.apple_sw   <= 1'b1;
            sel_o.overlay_sw <= FORCE_OVERLAY;
        end else begin
            // the port bit rides along so the vdp sees data or register mode
            sel_o.vdp_wr    <= wr && vdp_addr;
            sel_o.vdp_rd    <= rd && vdp_addr;
            sel_o.vdp_mode  <= cyc.addr[0];
            sel_o.vdp_reset <= wr && (cyc.addr == ssp_pkg::off_vdp_reset);

            // psg port: C writes data, D latches the register number
            // and a read at E or F returns the selected register
            sel_o.psg_addr_wr <= wr && psg_addr && cyc.addr[0];
            sel_o.psg_data_wr <= wr && psg_addr && !cyc.addr[0];
            sel_o.psg_data_rd <= rd && psg_addr && cyc.addr[1];

            // soft switches move on the same edge that registers the strobes
            if (wr) begin
                case (cyc.addr)
                    ssp_pkg::off_apple_off:   sel_o.apple_sw   <= 1'b0;
                    ssp_pkg::off_apple_on:    sel_o.apple_sw   <= 1'b1;
                    ssp_pkg::off_overlay_off: sel_o.overlay_sw <= FORCE_OVERLAY;
                    ssp_pkg::off_overlay_on:  sel_o.overlay_sw <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // write data is captured on every cycle, consumers look at it only with a strobe
    always_ff @(posedge a2bus_if.clk_logic) begin
        wr_data_o <= cyc.data;
    end

endmodule

`default_nettype wire

//--- hdl/ssp_overlay.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_overlay #(
    parameter bit ENABLE = 1'b1
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                apple_sw_i,
    input  logic                overlay_sw_i,
    input  logic                ext_video_i,
    input  ssp_pkg::rgb8_t      apple_pix_i,
    input  ssp_pkg::vdp_pixel_t vdp_pix_i,
    output ssp_pkg::rgb8_t      pix_o
);

    logic           vdp_black;
    logic           use_vdp;
    ssp_pkg::rgb8_t mix;

    assign vdp_black = (vdp_pix_i.r == 4'h0) && (vdp_pix_i.g == 4'h0) && (vdp_pix_i.b == 4'h0);

    // the original card keys on black, external video mode keys on the
    // transparent flag so that black vdp areas can cover the apple picture
    assign use_vdp = ENABLE && overlay_sw_i && vdp_pix_i.valid &&
                     (ext_video_i ? !vdp_pix_i.transparent : !vdp_black);

    always_comb begin
        if (use_vdp) begin
            mix.r = {vdp_pix_i.r, 4'h0};
            mix.g = {vdp_pix_i.g, 4'h0};
            mix.b = {vdp_pix_i.b, 4'h0};
        end else if (apple_sw_i) begin
            mix = apple_pix_i;
        end else begin
            // apple video switched off shows black behind the vdp
            mix = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pix_o <= '0;
        end else begin
            pix_o <= mix;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ssp_pkg.sv
`default_nettype none

package ssp_pkg;

    // card offsets within the slot device-select range, from addr[3:0]
    // the two vdp ports share addr[3:1] and are told apart by addr[0]
    localparam logic [3:0] off_vdp_data    = 4'h0;
    localparam logic [3:0] off_vdp_reg     = 4'h1;

    // video soft switches, a write to any of these flips one level
    localparam logic [3:0] off_apple_off   = 4'h3;
    localparam logic [3:0] off_apple_on    = 4'h4;
    localparam logic [3:0] off_overlay_off = 4'h5;
    localparam logic [3:0] off_overlay_on  = 4'h6;

    // a write here resets the vdp register file
    localparam logic [3:0] off_vdp_reset   = 4'h7;

    // psg occupies C to F, only addr[3:2] of this base is compared
    localparam logic [3:0] off_psg_base    = 4'hC;

    // one access on the slot, strobe is high for a single clock
    typedef struct packed {
        logic       strobe;
        logic       rw_n;
        logic [3:0] addr;
        logic [7:0] data;
    } bus_cycle_t;

    // full depth pixel, used for the apple input and the mixed output
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    // 12 bit vdp colour plus the flags that come from the renderer
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       transparent;
        logic       valid;
    } vdp_pixel_t;

    // registered selects, the last two are levels rather than strobes
    typedef struct packed {
        logic vdp_wr;
        logic vdp_rd;
        logic vdp_mode;
        logic vdp_reset;
        logic psg_addr_wr;
        logic psg_data_wr;
        logic psg_data_rd;
        logic apple_sw;
        logic overlay_sw;
    } card_sel_t;

endpackage

`default_nettype wire

//--- hdl/ssp_psg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_psg_regs (
    input  logic               clk_i,
    input  logic               reset_i,
    input  ssp_pkg::card_sel_t sel_i,
    input  logic [7:0]         wr_data_i,
    output logic [7:0]         rd_data_o,
    output logic               rd_en_o,
    output logic [15:0]        audio_o
);

    // registers 8, 9 and 10 are the channel A, B and C amplitudes
    localparam logic [3:0] AMP_BASE = 4'd8;

    logic [3:0] addr_q;
    logic [3:0] amp [3];
    logic       amp_hit;
    logic [1:0] amp_idx;

    assign amp_hit = (addr_q >= AMP_BASE) && (addr_q <= AMP_BASE + 4'd2);
    assign amp_idx = addr_q[1:0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr_q <= '0;
            amp    <= '{default: '0};
            rd_en_o <= 1'b0;
            audio_o <= '0;
        end else begin
            if (sel_i.psg_addr_wr) begin
                addr_q <= wr_data_i[3:0];
            end
            // writes outside the amplitude range have nothing to land in
            if (sel_i.psg_data_wr && amp_hit) begin
                amp[amp_idx] <= wr_data_i[3:0];
            end
            rd_en_o <= sel_i.psg_data_rd;
            // each 4 bit level goes to the top of a 12 bit slot
            audio_o <= {4'b0, amp[0], 8'b0} + {4'b0, amp[1], 8'b0} + {4'b0, amp[2], 8'b0};
        end
    end

    // readback of the latched register, unmodelled ones read as zero
    always_ff @(posedge clk_i) begin
        rd_data_o <= (sel_i.psg_data_rd && amp_hit) ? {4'b0, amp[amp_idx]} : 8'h00;
    end

endmodule

`default_nettype wire

//--- hdl/ssp_vdp_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ssp_vdp_regs (
    input  logic               clk_i,
    input  logic               reset_i,
    input  ssp_pkg::card_sel_t sel_i,
    input  logic [7:0]         wr_data_i,
    input  logic               frame_i,
    output logic [7:0]         rd_data_o,
    output logic               rd_en_o,
    output logic               irq_n_o,
    output logic               ext_video_o
);

    logic [7:0] regs [8];
    logic [7:0] latch_byte;
    logic       phase;
    logic       frame_flag;
    logic       reg_wr;
    logic       reg_rd;

    // mode 1 is the control port, mode 0 the vram data port
    assign reg_wr = sel_i.vdp_wr && sel_i.vdp_mode;
    assign reg_rd = sel_i.vdp_rd && sel_i.vdp_mode;

    always_ff @(posedge clk_i) begin
        if (reset_i || sel_i.vdp_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            phase      <= 1'b0;
            frame_flag <= 1'b0;
        end else begin
            if (reg_wr) begin
                // the first byte is parked, the second one names the target
                if (!phase) begin
                    phase <= 1'b1;
                end else begin
                    phase <= 1'b0;
                    // bit 7 marks a register write, otherwise it was an address setup
                    if (wr_data_i[7]) begin
                        regs[wr_data_i[2:0]] <= latch_byte;
                    end
                end
            end

            // a data port access or a status read restarts the two byte sequence
            if ((sel_i.vdp_wr || sel_i.vdp_rd) && !sel_i.vdp_mode) begin
                phase <= 1'b0;
            end
            if (reg_rd) begin
                phase <= 1'b0;
            end

            // a new frame beats the read that would clear the flag
            if (frame_i) begin
                frame_flag <= 1'b1;
            end else if (reg_rd) begin
                frame_flag <= 1'b0;
            end
        end
    end

    // the parked byte only matters together with phase
    always_ff @(posedge clk_i) begin
        if (reg_wr && !phase) begin
            latch_byte <= wr_data_i;
        end
    end

    // status read returns the flag in bit 7, data port reads are zero here
    always_ff @(posedge clk_i) begin
        rd_data_o <= reg_rd ? {frame_flag, 7'b0} : 8'h00;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_en_o <= 1'b0;
        end else begin
            rd_en_o <= sel_i.vdp_rd;
        end
    end

    // register 1 bit 5 is the frame interrupt enable
    assign irq_n_o     = !(frame_flag && regs[1][5]);
    assign ext_video_o = regs[0][0];

endmodule

`default_nettype wire
